// ==== src.f ====
src/rx_intf_pkg.sv
src/rx_sample_select.sv
src/byte_to_word_packer.sv
src/rx_word_fifo.sv
src/rx_dma_stream.sv
src/rx_intf.sv
dv/tb_clk_gen.sv
dv/tb_rx_intf.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the rx_intf testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -sv -Wno-fatal \
    --top-module tb_rx_intf \
    -Mdir obj_dir -o sim_rx_intf \
    -f src.f

./obj_dir/sim_rx_intf | tee "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== dv/tb_rx_intf.sv ====
// needs a timing-capable simulator with assertions on; DUT built with 16-word FIFO, fixed seed
`timescale 1ns/1ps

module tb_rx_intf
    import rx_intf_pkg::*;
();

    localparam int FIFO_DEPTH_LOG2 = 4;
    localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
    localparam int N_SAMPLE_ROWS   = 8;
    localparam int N_PKTS          = 4;

    typedef enum logic [1:0] {READY_HIGH, READY_RANDOM, READY_LOW} ready_mode_t;

    typedef struct packed {
        logic      loopback;
        logic      swap;
        logic      mute;
        adc_word_t adc;
        iq_pair_t  tx0;
        iq_pair_t  tx1;
        iq_pair_t  exp0;
        iq_pair_t  exp1;
    } sample_row_t;

    typedef struct packed {
        logic [15:0] len;
        logic        fcs;
        ready_mode_t mode;
    } pkt_row_t;

    // ADC word is {ant1, ant0}; swap exchanges halves, mute then zeroes the low half
    localparam sample_row_t SAMPLE_ROWS [N_SAMPLE_ROWS] = '{
        '{1'b0, 1'b0, 1'b0, 64'hA1A1_0001_B2B2_0002, 32'hC0C0_0001, 32'hD0D0_0001,
          32'hB2B2_0002, 32'hA1A1_0001},
        '{1'b0, 1'b1, 1'b0, 64'hA1A1_0011_B2B2_0012, 32'hC0C0_0011, 32'hD0D0_0011,
          32'hA1A1_0011, 32'hB2B2_0012},
        '{1'b0, 1'b0, 1'b1, 64'hA1A1_0021_B2B2_0022, 32'hC0C0_0021, 32'hD0D0_0021,
          32'h0000_0000, 32'hA1A1_0021},
        '{1'b0, 1'b1, 1'b1, 64'hA1A1_0031_B2B2_0032, 32'hC0C0_0031, 32'hD0D0_0031,
          32'h0000_0000, 32'hB2B2_0032},
        // loopback ignores swap and mute
        '{1'b1, 1'b0, 1'b0, 64'hA1A1_0041_B2B2_0042, 32'hC0C0_0041, 32'hD0D0_0041,
          32'hC0C0_0041, 32'hD0D0_0041},
        '{1'b1, 1'b1, 1'b0, 64'hA1A1_0051_B2B2_0052, 32'hC0C0_0051, 32'hD0D0_0051,
          32'hC0C0_0051, 32'hD0D0_0051},
        '{1'b1, 1'b0, 1'b1, 64'hA1A1_0061_B2B2_0062, 32'hC0C0_0061, 32'hD0D0_0061,
          32'hC0C0_0061, 32'hD0D0_0061},
        '{1'b1, 1'b1, 1'b1, 64'hA1A1_0071_B2B2_0072, 32'hC0C0_0071, 32'hD0D0_0071,
          32'hC0C0_0071, 32'hD0D0_0071}
    };

    // the held-low packet overruns the FIFO
    localparam pkt_row_t PKTS [N_PKTS] = '{
        '{16'd8,   1'b1, READY_HIGH},
        '{16'd13,  1'b0, READY_RANDOM},
        '{16'd1,   1'b1, READY_RANDOM},
        '{16'd200, 1'b1, READY_LOW}
    };

    logic        clk;
    logic        rst;
    adc_word_t   adc_data;
    logic        adc_valid;
    iq_pair_t    iq0_from_tx;
    iq_pair_t    iq1_from_tx;
    logic        iq_valid_from_tx;
    logic        loopback_en;
    logic        ant_swap;
    logic        mute_ant0;
    iq_pair_t    sample0;
    iq_pair_t    sample1;
    logic        sample_strobe;
    rx_byte_t    byte_in;
    logic        byte_in_strobe;
    logic        pkt_header_valid_strobe;
    logic        fcs_in_strobe;
    logic        fcs_ok;
    logic        m_axis_tvalid;
    rx_word_t    m_axis_tdata;
    logic        m_axis_tlast;
    logic        m_axis_tready;
    logic        rx_pkt_intr;
    logic        rx_overflow;

    ready_mode_t ready_mode;
    logic [31:0] ready_rnd;
    rx_word_t    exp_data [$];
    logic        exp_last [$];
    rx_byte_t    pkt_bytes [$];
    pkt_sn_t     sn_next;
    int          cycle_count;
    int          timeout_limit;
    int          intr_count;
    int          exp_intr;
    logic        stall_prev;
    logic        last_prev;
    rx_word_t    held_data;
    logic        held_last;

    tb_clk_gen #(.PERIOD_NS(20)) u_clk_gen (.clk(clk));

    rx_intf #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) uut (
        .clk                     (clk),
        .rst                     (rst),
        .adc_data                (adc_data),
        .adc_valid               (adc_valid),
        .iq0_from_tx             (iq0_from_tx),
        .iq1_from_tx             (iq1_from_tx),
        .iq_valid_from_tx        (iq_valid_from_tx),
        .loopback_en             (loopback_en),
        .ant_swap                (ant_swap),
        .mute_ant0               (mute_ant0),
        .sample0                 (sample0),
        .sample1                 (sample1),
        .sample_strobe           (sample_strobe),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .m_axis_tvalid           (m_axis_tvalid),
        .m_axis_tdata            (m_axis_tdata),
        .m_axis_tlast            (m_axis_tlast),
        .m_axis_tready           (m_axis_tready),
        .rx_pkt_intr             (rx_pkt_intr),
        .rx_overflow             (rx_overflow)
    );

    task automatic stop_failed();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] actual,
                                   input logic [63:0] expected);
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                 expected);
        stop_failed();
    endtask

    task automatic report_problem(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_sample_row(input int r);
        sample_row_t row;
        row = SAMPLE_ROWS[r];
        loopback_en      = row.loopback;
        ant_swap         = row.swap;
        mute_ant0        = row.mute;
        adc_data         = row.adc;
        iq0_from_tx      = row.tx0;
        iq1_from_tx      = row.tx1;
        adc_valid        = !row.loopback;
        iq_valid_from_tx = row.loopback;
        next_cycle();
        assert (sample_strobe == 1'b1) else report_mismatch("sample_strobe", sample_strobe, 1);
        assert (sample0 == row.exp0) else report_mismatch("sample0", sample0, row.exp0);
        assert (sample1 == row.exp1) else report_mismatch("sample1", sample1, row.exp1);
        // only the unselected source is valid now
        adc_valid        = row.loopback;
        iq_valid_from_tx = !row.loopback;
        next_cycle();
        assert (sample_strobe == 1'b0) else report_mismatch("sample_strobe", sample_strobe, 0);
        adc_valid        = 1'b0;
        iq_valid_from_tx = 1'b0;
    endtask

    // reference packing, keeps only the first keep words of the packet
    task automatic model_packet(input int len, input logic fcs, input pkt_sn_t sn,
                                input int keep);
        rx_word_t w;
        rx_word_t st;
        int       n_words;
        w       = '0;
        n_words = 0;
        for (int k = 0; k < len; k++)
        begin
            w[8*(k%8) +: 8] = pkt_bytes[k];
            if ((k % 8 == 7) || (k == len - 1))
            begin
                if (n_words < keep)
                begin
                    exp_data.push_back(w);
                    exp_last.push_back(1'b0);
                end
                n_words++;
                w = '0;
            end
        end
        st                               = '0;
        st[STAT_FCS_OK_BIT]              = fcs;
        st[STAT_LEN_LSB +: 16]           = len[15:0];
        st[STAT_SN_LSB +: 16]            = sn;
        if (n_words < keep)
        begin
            exp_data.push_back(st);
            exp_last.push_back(1'b1);
        end
    endtask

    task automatic send_packet(input int p);
        pkt_row_t    pr;
        logic [31:0] rnd;
        int          keep;
        pr = PKTS[p];
        pkt_bytes.delete();
        for (int k = 0; k < pr.len; k++)
        begin
            rnd = $urandom;
            pkt_bytes.push_back(rnd[7:0]);
        end
        keep = (pr.mode == READY_LOW) ? FIFO_DEPTH : int'(pr.len) + 2;
        model_packet(int'(pr.len), pr.fcs, sn_next, keep);
        ready_mode = pr.mode;
        pkt_header_valid_strobe = 1'b1;
        next_cycle();
        pkt_header_valid_strobe = 1'b0;
        for (int k = 0; k < pr.len; k++)
        begin
            rnd = $urandom;
            // an idle byte cycle now and then
            if (rnd[1:0] == 2'd0)
            begin
                next_cycle();
            end
            byte_in        = pkt_bytes[k];
            byte_in_strobe = 1'b1;
            next_cycle();
            byte_in_strobe = 1'b0;
        end
        fcs_in_strobe = 1'b1;
        fcs_ok        = pr.fcs;
        next_cycle();
        fcs_in_strobe = 1'b0;
        repeat (3) next_cycle();
        sn_next++;
    endtask

    task automatic wait_for_drain();
        while (exp_data.size() != 0 || m_axis_tvalid)
        begin
            @(negedge clk);
        end
        next_cycle();
    endtask

    always @(posedge clk)
    begin
        #1;
        ready_rnd = $urandom;
        case (ready_mode)
            READY_HIGH:   m_axis_tready = 1'b1;
            READY_RANDOM: m_axis_tready = ready_rnd[0];
            default:      m_axis_tready = 1'b0;
        endcase
    end

    // stream monitor, outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            stall_prev = 1'b0;
            last_prev  = 1'b0;
        end
        else
        begin
            if (stall_prev)
            begin
                assert (m_axis_tvalid) else report_problem("valid dropped before its beat");
                assert (m_axis_tdata == held_data)
                    else report_mismatch("m_axis_tdata", m_axis_tdata, held_data);
                assert (m_axis_tlast == held_last)
                    else report_mismatch("m_axis_tlast", m_axis_tlast, held_last);
            end
            assert (rx_pkt_intr == last_prev)
                else report_mismatch("rx_pkt_intr", rx_pkt_intr, last_prev);
            if (rx_pkt_intr)
            begin
                intr_count++;
            end
            if (m_axis_tvalid && m_axis_tready)
            begin
                assert (exp_data.size() != 0) else report_problem("unexpected stream beat");
                if (exp_data.size() != 0)
                begin
                    assert (m_axis_tdata == exp_data[0])
                        else report_mismatch("m_axis_tdata", m_axis_tdata, exp_data[0]);
                    assert (m_axis_tlast == exp_last[0])
                        else report_mismatch("m_axis_tlast", m_axis_tlast, exp_last[0]);
                    void'(exp_data.pop_front());
                    void'(exp_last.pop_front());
                end
            end
            stall_prev = m_axis_tvalid && !m_axis_tready;
            last_prev  = m_axis_tvalid && m_axis_tready && m_axis_tlast;
            held_data  = m_axis_tdata;
            held_last  = m_axis_tlast;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit)
        begin
            $display("Failure at %0t ns: run did not finish within %0d cycles", $time,
                     timeout_limit);
            stop_failed();
        end
    end

    initial
    begin
        void'($urandom(32'h9eb1));
        rst                     = 1'b1;
        adc_data                = '0;
        adc_valid               = 1'b0;
        iq0_from_tx             = '0;
        iq1_from_tx             = '0;
        iq_valid_from_tx        = 1'b0;
        loopback_en             = 1'b0;
        ant_swap                = 1'b0;
        mute_ant0               = 1'b0;
        byte_in                 = '0;
        byte_in_strobe          = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        m_axis_tready           = 1'b0;
        ready_mode              = READY_HIGH;
        sn_next                 = '0;
        intr_count              = 0;
        exp_intr                = 0;
        timeout_limit           = N_SAMPLE_ROWS;
        for (int p = 0; p < N_PKTS; p++)
        begin
            timeout_limit += int'(PKTS[p].len) + 40;
            if (PKTS[p].mode != READY_LOW)
            begin
                exp_intr++;
            end
        end
        timeout_limit *= 4;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!sample_strobe) else report_mismatch("sample_strobe", sample_strobe, 0);
        assert (!m_axis_tvalid) else report_mismatch("m_axis_tvalid", m_axis_tvalid, 0);
        assert (!rx_pkt_intr) else report_mismatch("rx_pkt_intr", rx_pkt_intr, 0);
        assert (!rx_overflow) else report_mismatch("rx_overflow", rx_overflow, 0);

        for (int r = 0; r < N_SAMPLE_ROWS; r++)
        begin
            apply_sample_row(r);
        end

        for (int p = 0; p < N_PKTS; p++)
        begin
            if (PKTS[p].mode == READY_LOW)
            begin
                assert (!rx_overflow) else report_mismatch("rx_overflow", rx_overflow, 0);
            end
            send_packet(p);
            if (PKTS[p].mode == READY_LOW)
            begin
                assert (rx_overflow) else report_mismatch("rx_overflow", rx_overflow, 1);
                ready_mode = READY_HIGH;
            end
            wait_for_drain();
        end

        // sticky until the next reset
        assert (rx_overflow) else report_mismatch("rx_overflow", rx_overflow, 1);
        assert (intr_count == exp_intr) else report_mismatch("intr_count", intr_count, exp_intr);
        rst = 1'b1;
        next_cycle();
        rst = 1'b0;
        assert (!rx_overflow) else report_mismatch("rx_overflow", rx_overflow, 0);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
// free-running testbench clock, starts low, period given in ns
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== src/rx_intf.sv ====
// single clock domain, settings are static levels; stream output follows valid/ready
`timescale 1ns/1ps

module rx_intf
    import rx_intf_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 4
)
(
    input  logic      clk,
    input  logic      rst,

    // ADC and transmit loopback
    input  adc_word_t adc_data,
    input  logic      adc_valid,
    input  iq_pair_t  iq0_from_tx,
    input  iq_pair_t  iq1_from_tx,
    input  logic      iq_valid_from_tx,
    input  logic      loopback_en,
    input  logic      ant_swap,
    input  logic      mute_ant0,

    // to the demodulator
    output iq_pair_t  sample0,
    output iq_pair_t  sample1,
    output logic      sample_strobe,

    // decoded packet from the demodulator
    input  rx_byte_t  byte_in,
    input  logic      byte_in_strobe,
    input  logic      pkt_header_valid_strobe,
    input  logic      fcs_in_strobe,
    input  logic      fcs_ok,

    // DMA stream and host signals
    output logic      m_axis_tvalid,
    output rx_word_t  m_axis_tdata,
    output logic      m_axis_tlast,
    input  logic      m_axis_tready,
    output logic      rx_pkt_intr,
    output logic      rx_overflow
);

    rx_word_t word;
    logic     word_last;
    logic     word_strobe;

    rx_sample_select u_sample_select (
        .clk              (clk),
        .rst              (rst),
        .adc_data         (adc_data),
        .adc_valid        (adc_valid),
        .iq0_from_tx      (iq0_from_tx),
        .iq1_from_tx      (iq1_from_tx),
        .iq_valid_from_tx (iq_valid_from_tx),
        .loopback_en      (loopback_en),
        .ant_swap         (ant_swap),
        .mute_ant0        (mute_ant0),
        .sample0          (sample0),
        .sample1          (sample1),
        .sample_strobe    (sample_strobe)
    );

    byte_to_word_packer u_packer (
        .clk                     (clk),
        .rst                     (rst),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .word                    (word),
        .word_last               (word_last),
        .word_strobe             (word_strobe)
    );

    rx_dma_stream #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_dma_stream (
        .clk           (clk),
        .rst           (rst),
        .word          (word),
        .word_last     (word_last),
        .word_strobe   (word_strobe),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .rx_pkt_intr   (rx_pkt_intr),
        .rx_overflow   (rx_overflow)
    );

endmodule

// ==== src/rx_dma_stream.sv ====
// no back-pressure towards the packer; a word arriving at a full FIFO is dropped and flagged
`timescale 1ns/1ps

module rx_dma_stream
    import rx_intf_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 4
)
(
    input  logic     clk,
    input  logic     rst,
    input  rx_word_t word,
    input  logic     word_last,
    input  logic     word_strobe,
    input  logic     m_axis_tready,
    output logic     m_axis_tvalid,
    output rx_word_t m_axis_tdata,
    output logic     m_axis_tlast,
    output logic     rx_pkt_intr,
    output logic     rx_overflow
);

    logic fifo_empty;
    logic beat_taken;

    assign m_axis_tvalid = !fifo_empty;
    assign beat_taken    = m_axis_tvalid && m_axis_tready;

    rx_word_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (word),
        .wr_last  (word_last),
        .wr_en    (word_strobe),
        .rd_en    (beat_taken),
        .rd_data  (m_axis_tdata),
        .rd_last  (m_axis_tlast),
        .empty    (fifo_empty),
        .overflow (rx_overflow)
    );

    // one pulse per packet, after its status beat is accepted
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_pkt_intr <= 1'b0;
        end
        else
        begin
            rx_pkt_intr <= beat_taken && m_axis_tlast;
        end
    end

endmodule

// ==== src/rx_word_fifo.sv ====
// show-ahead FIFO, depth 2**FIFO_DEPTH_LOG2 with FIFO_DEPTH_LOG2 >= 1; writes when full are lost
`timescale 1ns/1ps

module rx_word_fifo
    import rx_intf_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 4
)
(
    input  logic     clk,
    input  logic     rst,
    input  rx_word_t wr_data,
    input  logic     wr_last,
    input  logic     wr_en,
    input  logic     rd_en,
    output rx_word_t rd_data,
    output logic     rd_last,
    output logic     empty,
    output logic     overflow
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    // last flag stored above the data word
    logic [$bits(rx_word_t):0] mem [DEPTH];

    logic [FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;
    logic                     full;
    logic                     do_write;
    logic                     do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                   (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (wr_en && full)
            begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= {wr_last, wr_data};
        end
    end

    // head entry, visible before the pop
    assign {rd_last, rd_data} = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

endmodule

// ==== src/byte_to_word_packer.sv ====
// bytes only count between header and FCS strobe; FCS needs 2 idle byte cycles after it
`timescale 1ns/1ps

module byte_to_word_packer
    import rx_intf_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  rx_byte_t byte_in,
    input  logic     byte_in_strobe,
    input  logic     pkt_header_valid_strobe,
    input  logic     fcs_in_strobe,
    input  logic     fcs_ok,
    output rx_word_t word,
    output logic     word_last,
    output logic     word_strobe
);

    typedef enum logic [1:0] {ST_IDLE, ST_COLLECT, ST_FLUSH, ST_STATUS} pack_state_t;

    pack_state_t state;
    rx_word_t    acc;
    rx_word_t    data_word;
    rx_word_t    status_word;
    logic        data_strobe;
    logic [2:0]  lane;
    pkt_len_t    byte_cnt;
    pkt_sn_t     pkt_sn;
    logic        fcs_ok_q;
    logic        take_byte;

    assign take_byte = byte_in_strobe && (state == ST_COLLECT) &&
                       !pkt_header_valid_strobe && !fcs_in_strobe;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= ST_IDLE;
            lane        <= 3'd0;
            byte_cnt    <= '0;
            pkt_sn      <= '0;
            data_strobe <= 1'b0;
        end
        else
        begin
            data_strobe <= take_byte && (lane == 3'd7);
            case (state)
                ST_IDLE:
                begin
                    if (pkt_header_valid_strobe)
                    begin
                        state    <= ST_COLLECT;
                        lane     <= 3'd0;
                        byte_cnt <= '0;
                    end
                end
                ST_COLLECT:
                begin
                    // a new header restarts the packet
                    if (pkt_header_valid_strobe)
                    begin
                        lane     <= 3'd0;
                        byte_cnt <= '0;
                    end
                    else if (fcs_in_strobe)
                    begin
                        state <= (lane != 3'd0) ? ST_FLUSH : ST_STATUS;
                    end
                    else if (take_byte)
                    begin
                        lane     <= lane + 3'd1;
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
                ST_FLUSH:
                begin
                    state <= ST_STATUS;
                end
                default:
                begin
                    pkt_sn <= pkt_sn + 16'd1;
                    state  <= ST_IDLE;
                end
            endcase
        end
    end

    // byte lanes; acc starts from zero so a partial word is already padded
    always_ff @(posedge clk)
    begin
        if (pkt_header_valid_strobe)
        begin
            acc <= '0;
        end
        else if (take_byte)
        begin
            if (lane == 3'd7)
            begin
                data_word <= {byte_in, acc[55:0]};
                acc       <= '0;
            end
            else
            begin
                acc[{lane, 3'b000} +: $bits(rx_byte_t)] <= byte_in;
            end
        end
        if (fcs_in_strobe)
        begin
            fcs_ok_q <= fcs_ok;
        end
    end

    always_comb
    begin
        status_word = '0;
        status_word[STAT_FCS_OK_BIT] = fcs_ok_q;
        status_word[STAT_LEN_LSB +: $bits(pkt_len_t)] = byte_cnt;
        status_word[STAT_SN_LSB +: $bits(pkt_sn_t)] = pkt_sn;
    end

    // end words come straight from the state, full words from data_word
    assign word = (state == ST_FLUSH)  ? acc :
                  (state == ST_STATUS) ? status_word : data_word;
    assign word_strobe = data_strobe || (state == ST_FLUSH) || (state == ST_STATUS);
    assign word_last   = (state == ST_STATUS);

endmodule

// ==== src/rx_sample_select.sv ====
// source, swap and mute are level settings sampled each cycle; swap and mute act on ADC data only
`timescale 1ns/1ps

module rx_sample_select
    import rx_intf_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  adc_word_t adc_data,
    input  logic      adc_valid,
    input  iq_pair_t  iq0_from_tx,
    input  iq_pair_t  iq1_from_tx,
    input  logic      iq_valid_from_tx,
    input  logic      loopback_en,
    input  logic      ant_swap,
    input  logic      mute_ant0,
    output iq_pair_t  sample0,
    output iq_pair_t  sample1,
    output logic      sample_strobe
);

    localparam int PAIR_W = $bits(iq_pair_t);

    adc_word_t adc_swapped;
    adc_word_t adc_final;
    logic      src_valid;

    // exchange the two antenna lanes, then optionally blank antenna 0
    always_comb
    begin
        if (ant_swap)
        begin
            adc_swapped = {adc_data[PAIR_W-1:0], adc_data[2*PAIR_W-1:PAIR_W]};
        end
        else
        begin
            adc_swapped = adc_data;
        end
        adc_final = adc_swapped;
        if (mute_ant0)
        begin
            adc_final[PAIR_W-1:0] = '0;
        end
    end

    assign src_valid = loopback_en ? iq_valid_from_tx : adc_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sample_strobe <= 1'b0;
        end
        else
        begin
            sample_strobe <= src_valid;
        end
    end

    // sample registers load only with a valid input
    always_ff @(posedge clk)
    begin
        if (src_valid)
        begin
            if (loopback_en)
            begin
                sample0 <= iq0_from_tx;
                sample1 <= iq1_from_tx;
            end
            else
            begin
                sample0 <= adc_final[PAIR_W-1:0];
                sample1 <= adc_final[2*PAIR_W-1:PAIR_W];
            end
        end
    end

endmodule

// ==== src/rx_intf_pkg.sv ====
// shared widths and status-word layout; IQ pairs are {I, Q}, ADC word is {ant1, ant0}
package rx_intf_pkg;

    // one I or Q component
    localparam int IQ_DATA_WIDTH = 16;

    typedef logic [IQ_DATA_WIDTH-1:0] iq_comp_t;

    // one antenna sample, I in the upper half
    typedef logic [2*IQ_DATA_WIDTH-1:0] iq_pair_t;

    // antenna 0 in the low pair, antenna 1 in the high pair
    typedef logic [4*IQ_DATA_WIDTH-1:0] adc_word_t;

    // decoded byte from the demodulator
    typedef logic [7:0] rx_byte_t;

    // DMA word towards the host
    typedef logic [63:0] rx_word_t;

    typedef logic [15:0] pkt_len_t;
    typedef logic [15:0] pkt_sn_t;

    // status word fields, all other bits zero
    localparam int STAT_FCS_OK_BIT = 0;
    localparam int STAT_LEN_LSB    = 16;
    localparam int STAT_SN_LSB     = 32;

endpackage
